// File: Makefile
TOP       ?= tb_motor_ctrl
FILELIST  ?= project.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bldc_pkg.sv
`default_nettype none

package bldc_pkg;

    // Widths
    typedef logic [5:0]         angle_t;     // Modulo 64 electrical angle
    typedef logic [7:0]         sine_t;
    typedef logic [7:0]         volt_t;      // 0 to VOLT_MAX
    typedef logic [7:0]         duty_t;      // PWM ticks high per period
    typedef logic signed [15:0] velocity_t;
    typedef logic signed [7:0]  offset_t;
    typedef logic [15:0]        feedback_t;

    typedef enum logic [1:0] {
        mode_run,
        mode_calibrate,
        mode_test
    } mode_e;

    // Sine table geometry
    localparam int TABLE_LEN   = 64;
    localparam int LEAD_ANGLE  = 16;  // Quarter turn
    localparam int PHASE_V_OFS = 21;
    localparam int PHASE_W_OFS = 42;
    localparam int FB_SHIFT    = 4;

    // Voltage saturation, also the duty divisor
    localparam int VOLT_MAX = 100;

    // PWM timing
    localparam int PWM_DIV    = 4;
    localparam int PWM_PERIOD = 255;

    // Holding register depth in the PWM bank
    localparam int DUTY_CREDITS = 1;

endpackage

`default_nettype wire

// File: duty_calc.sv
`timescale 1ns/100ps
`default_nettype none

module duty_calc
    import bldc_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  angle_t angle_u,
    input  angle_t angle_v,
    input  angle_t angle_w,
    input  volt_t  volt,
    duty_if.src    dif
);

    typedef enum logic [2:0] {
        idle,
        lookup,
        multiply,
        store,
        send
    } calc_state_e;

    calc_state_e state;
    logic [1:0]  ph;  // 0 u, 1 v, 2 w
    angle_t      ang_u_s;
    angle_t      ang_v_s;
    angle_t      ang_w_s;
    angle_t      rom_angle;
    volt_t       volt_s;
    sine_t       sine_val;
    logic        mult_start;
    logic        mult_done;
    logic [15:0] mult_product;
    duty_t       quot;
    logic [1:0]  credits;
    logic        send_fire;

    always_comb begin
        case (ph)
            2'd0:    rom_angle = ang_u_s;
            2'd1:    rom_angle = ang_v_s;
            default: rom_angle = ang_w_s;
        endcase
    end

    assign mult_start = (state == lookup);
    assign quot       = duty_t'(mult_product / VOLT_MAX);
    assign send_fire  = (state == send) && (credits != '0);

    sine_rom rom_i (
        .angle (rom_angle),
        .value (sine_val)
    );

    shift_add_mult mult_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (mult_start),
        .a       (sine_val),
        .b       (volt_s),
        .product (mult_product),
        .done    (mult_done)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
            ph    <= '0;
        end else begin
            case (state)
                idle: begin
                    ph    <= '0;
                    state <= lookup;
                end
                lookup:   state <= multiply;
                multiply: if (mult_done) state <= store;
                store: begin
                    if (ph == 2'd2) begin
                        state <= send;
                    end else begin
                        ph    <= ph + 2'd1;
                        state <= lookup;
                    end
                end
                send:     if (send_fire) state <= idle;  // Stall here without credit
                default:  state <= idle;
            endcase
        end
    end

    // Snapshot of the live commands for one set
    always_ff @(posedge clk) begin
        if (state == idle) begin
            ang_u_s <= angle_u;
            ang_v_s <= angle_v;
            ang_w_s <= angle_w;
            volt_s  <= volt;
        end
        if (state == store) begin
            case (ph)
                2'd0:    dif.duty_u <= quot;
                2'd1:    dif.duty_v <= quot;
                default: dif.duty_w <= quot;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits        <= 2'(DUTY_CREDITS);
            dif.duty_valid <= 1'b0;
        end else begin
            dif.duty_valid <= send_fire;
            credits        <= credits + 2'(dif.credit) - 2'(send_fire);
        end
    end

    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= 2'(DUTY_CREDITS))
        else $error("duty_calc: credit count above limit");

endmodule

`default_nettype wire

// File: duty_if.sv
`timescale 1ns/100ps
`default_nettype none

interface duty_if
    import bldc_pkg::*;
();

    duty_t duty_u;
    duty_t duty_v;
    duty_t duty_w;
    logic  duty_valid;  // One cycle, marks a complete set
    logic  credit;      // Returned when the set goes active

    modport src (
        output duty_u, duty_v, duty_w, duty_valid,
        input  credit
    );

    modport snk (
        input  duty_u, duty_v, duty_w, duty_valid,
        output credit
    );

endinterface

`default_nettype wire

// File: motor_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

module motor_ctrl_top
    import bldc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      enable,
    input  mode_e     mode,
    input  velocity_t velocity,
    input  offset_t   offset,
    input  feedback_t feedback,
    output logic      u,
    output logic      v,
    output logic      w,
    output logic      u_n,
    output logic      v_n,
    output logic      w_n
);

    angle_t angle_u;
    angle_t angle_v;
    angle_t angle_w;
    volt_t  volt;

    duty_if dif_i ();

    phase_angle angle_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .mode     (mode),
        .velocity (velocity),
        .offset   (offset),
        .feedback (feedback),
        .angle_u  (angle_u),
        .angle_v  (angle_v),
        .angle_w  (angle_w),
        .volt     (volt)
    );

    duty_calc calc_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .angle_u (angle_u),
        .angle_v (angle_v),
        .angle_w (angle_w),
        .volt    (volt),
        .dif     (dif_i.src)
    );

    pwm_bank pwm_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (enable),
        .dif    (dif_i.snk),
        .u      (u),
        .v      (v),
        .w      (w),
        .u_n    (u_n),
        .v_n    (v_n),
        .w_n    (w_n)
    );

endmodule

`default_nettype wire

// File: phase_angle.sv
`timescale 1ns/100ps
`default_nettype none

module phase_angle
    import bldc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  mode_e     mode,
    input  velocity_t velocity,
    input  offset_t   offset,
    input  feedback_t feedback,
    output angle_t    angle_u,
    output angle_t    angle_v,
    output angle_t    angle_w,
    output volt_t     volt
);

    angle_t            fb_angle;
    angle_t            lead;
    angle_t            base;
    logic signed [16:0] vel_ext;
    logic [16:0]       vel_mag;
    volt_t             volt_next;

    always_comb begin
        fb_angle = angle_t'(feedback >> FB_SHIFT);
        if (velocity > 0) begin
            lead = angle_t'(LEAD_ANGLE);
        end else if (velocity < 0) begin
            lead = angle_t'(-LEAD_ANGLE);  // Wraps to 48
        end else begin
            lead = '0;
        end

        case (mode)
            mode_test:      base = angle_t'(offset);  // Feedback ignored
            mode_calibrate: base = fb_angle + angle_t'(offset);
            default:        base = fb_angle + angle_t'(offset) + lead;
        endcase

        // Magnitude with one spare bit so -32768 survives
        vel_ext = velocity;
        vel_mag = vel_ext[16] ? 17'(-vel_ext) : 17'(vel_ext);
        volt_next = (vel_mag > VOLT_MAX) ? volt_t'(VOLT_MAX) : volt_t'(vel_mag);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            angle_u <= '0;
            angle_v <= '0;
            angle_w <= '0;
            volt    <= '0;
        end else begin
            angle_u <= base;
            angle_v <= base + angle_t'(PHASE_V_OFS);
            angle_w <= base + angle_t'(PHASE_W_OFS);
            volt    <= volt_next;
        end
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
bldc_pkg.sv
duty_if.sv
phase_angle.sv
sine_rom.sv
shift_add_mult.sv
duty_calc.sv
pwm_bank.sv
motor_ctrl_top.sv
tb_motor_ctrl.sv

// File: pwm_bank.sv
`timescale 1ns/100ps
`default_nettype none

module pwm_bank
    import bldc_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic enable,
    duty_if.snk  dif,
    output logic u,
    output logic v,
    output logic w,
    output logic u_n,
    output logic v_n,
    output logic w_n
);

    logic [1:0] pre;
    logic       tick;
    logic       period_end;
    logic       load;
    duty_t      cnt;
    duty_t      hold_u;
    duty_t      hold_v;
    duty_t      hold_w;
    duty_t      act_u;
    duty_t      act_v;
    duty_t      act_w;
    logic       full;  // Holding register occupied
    logic       hi_u;
    logic       hi_v;
    logic       hi_w;

    assign tick       = (pre == 2'(PWM_DIV - 1));
    assign period_end = tick && (cnt == duty_t'(PWM_PERIOD - 1));
    assign load       = period_end && full;
    assign dif.credit = load;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pre   <= '0;
            cnt   <= '0;
            full  <= 1'b0;
            act_u <= '0;
            act_v <= '0;
            act_w <= '0;
        end else begin
            pre <= tick ? 2'd0 : pre + 2'd1;
            if (tick) begin
                cnt <= period_end ? duty_t'(0) : cnt + duty_t'(1);
            end
            if (load) begin
                act_u <= hold_u;
                act_v <= hold_v;
                act_w <= hold_w;
                full  <= 1'b0;
            end else if (dif.duty_valid) begin
                full <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dif.duty_valid) begin
            hold_u <= dif.duty_u;
            hold_v <= dif.duty_v;
            hold_w <= dif.duty_w;
        end
    end

    assign hi_u = (cnt < act_u);
    assign hi_v = (cnt < act_v);
    assign hi_w = (cnt < act_w);

    // Enable low parks both switches of every leg
    assign u   = enable & hi_u;
    assign v   = enable & hi_v;
    assign w   = enable & hi_w;
    assign u_n = enable & ~hi_u;
    assign v_n = enable & ~hi_v;
    assign w_n = enable & ~hi_w;

    a_hold_free: assert property (@(posedge clk) disable iff (!rst_n)
        dif.duty_valid |-> !full)
        else $error("pwm_bank: duty set while holding register full");

endmodule

`default_nettype wire

// File: shift_add_mult.sv
`timescale 1ns/100ps
`default_nettype none

module shift_add_mult (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic [7:0]  a,
    input  logic [7:0]  b,
    output logic [15:0] product,
    output logic        done
);

    logic [15:0] mcand;  // Multiplicand, moves left each step
    logic [7:0]  mplier;
    logic [2:0]  steps;
    logic        busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            steps <= '0;
        end else if (start && !busy) begin
            busy  <= 1'b1;
            done  <= 1'b0;
            steps <= 3'd7;  // Bit 0 handled at load
        end else if (busy) begin
            steps <= steps - 3'd1;
            if (steps == 3'd1) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            product <= b[0] ? {8'd0, a} : 16'd0;
            mcand   <= {7'd0, a, 1'b0};
            mplier  <= b >> 1;
        end else if (busy) begin
            if (mplier[0]) begin
                product <= product + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n) busy |-> !start)
        else $error("shift_add_mult: start while busy");

    a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
        start |=> !done [*7] ##1 done)
        else $error("shift_add_mult: done not 8 cycles after start");

endmodule

`default_nettype wire

// File: sine_rom.sv
`timescale 1ns/100ps
`default_nettype none

module sine_rom
    import bldc_pkg::*;
(
    input  angle_t angle,
    output sine_t  value
);

    logic [4:0] pos;  // Position inside the half wave
    logic [4:0] idx;
    sine_t      q;

    always_comb begin
        pos = angle[4:0];
        // Falling part of each half reads the quarter backwards
        if (pos > 5'(TABLE_LEN / 4)) begin
            idx = 5'(TABLE_LEN / 2 - pos);
        end else begin
            idx = pos;
        end

        case (idx)
            5'd0:    q = 8'd127;
            5'd1:    q = 8'd139;
            5'd2:    q = 8'd151;
            5'd3:    q = 8'd163;
            5'd4:    q = 8'd175;
            5'd5:    q = 8'd186;
            5'd6:    q = 8'd197;
            5'd7:    q = 8'd207;
            5'd8:    q = 8'd216;
            5'd9:    q = 8'd225;
            5'd10:   q = 8'd232;
            5'd11:   q = 8'd239;
            5'd12:   q = 8'd244;
            5'd13:   q = 8'd248;
            5'd14:   q = 8'd251;
            5'd15:   q = 8'd253;
            default: q = 8'd254;  // Peak
        endcase

        // Negative half runs one step under the mirror and clips at zero
        if (!angle[5] || idx == '0) begin
            value = q;
        end else if (q >= 8'd253) begin
            value = '0;
        end else begin
            value = 8'd253 - q;
        end
    end

endmodule

`default_nettype wire

// File: tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH
`default_nettype none

// Table angle for one phase, wrapped into 0..63
function automatic int angle_ref(mode_e md, int vel, int ofs, int fb, int phase_ofs);
    int base;
    base = ofs;
    if (md != mode_test) begin
        base = base + (fb >> FB_SHIFT);
    end
    if (md == mode_run) begin
        if (vel > 0) base = base + LEAD_ANGLE;
        else if (vel < 0) base = base - LEAD_ANGLE;
    end
    return ((base + phase_ofs) % TABLE_LEN + TABLE_LEN) % TABLE_LEN;
endfunction

// Full wave from the 17-point quarter, lower half one step under the mirror
function automatic int sine_ref(int a);
    int quarter [0:16];
    int p;
    int s;
    quarter = '{127, 139, 151, 163, 175, 186, 197, 207, 216,
                225, 232, 239, 244, 248, 251, 253, 254};
    p = a % (TABLE_LEN / 2);
    s = (p <= TABLE_LEN / 4) ? quarter[p] : quarter[TABLE_LEN / 2 - p];
    if (a >= TABLE_LEN / 2 && p != 0) begin
        s = 126 - (s - 127);
        if (s < 0) s = 0;
    end
    return s;
endfunction

function automatic int volt_ref(int vel);
    int mag;
    mag = (vel < 0) ? -vel : vel;
    return (mag > VOLT_MAX) ? VOLT_MAX : mag;
endfunction

function automatic int duty_ref(int sine, int vlt);
    return (sine * vlt) / VOLT_MAX;
endfunction

`default_nettype wire
`endif

// File: tb_motor_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module tb_motor_ctrl
    import bldc_pkg::*;
();

    `include "tb_ref.svh"

    localparam int NUM_ROWS    = 11;
    localparam int PERIOD_CYC  = PWM_DIV * PWM_PERIOD;
    localparam int SETTLE_CYC  = 3 * PERIOD_CYC + 16;  // Small margin past the third boundary
    localparam int CYCLE_LIMIT = NUM_ROWS * 5 * PERIOD_CYC + 2000;

    typedef struct {
        logic   en;
        mode_e  md;
        int     vel;
        int     ofs;
        int     fb;
        angle_t ang_u;
        angle_t ang_v;
        angle_t ang_w;
        int     exp_u;
        int     exp_v;
        int     exp_w;
    } row_t;

    logic      clk;
    logic      rst_n;
    logic      enable;
    mode_e     mode;
    velocity_t velocity;
    offset_t   offset;
    feedback_t feedback;
    logic      u, v, w, u_n, v_n, w_n;

    row_t rows [NUM_ROWS];
    int   cycles = 0;
    int   errors = 0;
    int   failed_rows = 0;
    int   row_errors;

    motor_ctrl_top dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (enable),
        .mode     (mode),
        .velocity (velocity),
        .offset   (offset),
        .feedback (feedback),
        .u        (u),
        .v        (v),
        .w        (w),
        .u_n      (u_n),
        .v_n      (v_n),
        .w_n      (w_n)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run timed out after %0d cycles before all rows were checked", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic fill_row(input int i, input logic en, input mode_e md,
                            input int vel, input int ofs, input int fb);
        int vlt;
        vlt = volt_ref(vel);
        rows[i].en    = en;
        rows[i].md    = md;
        rows[i].vel   = vel;
        rows[i].ofs   = ofs;
        rows[i].fb    = fb;
        rows[i].ang_u = angle_t'(angle_ref(md, vel, ofs, fb, 0));
        rows[i].ang_v = angle_t'(angle_ref(md, vel, ofs, fb, PHASE_V_OFS));
        rows[i].ang_w = angle_t'(angle_ref(md, vel, ofs, fb, PHASE_W_OFS));
        // Disabled bridge keeps every high side off
        rows[i].exp_u = en ? duty_ref(sine_ref(int'(rows[i].ang_u)), vlt) : 0;
        rows[i].exp_v = en ? duty_ref(sine_ref(int'(rows[i].ang_v)), vlt) : 0;
        rows[i].exp_w = en ? duty_ref(sine_ref(int'(rows[i].ang_w)), vlt) : 0;
    endtask

    task automatic check_phase(input int row, input string name, input int got, input int duty);
        assert (got == PWM_DIV * duty) else begin
            $display("MISMATCH at %0t: row %0d phase %s high %0d cycles, expected %0d",
                     $time, row, name, got, PWM_DIV * duty);
            row_errors++;
        end
        assert (got <= PWM_DIV * 254) else begin
            $display("MISMATCH at %0t: row %0d phase %s high %0d cycles, above full scale",
                     $time, row, name, got);
            row_errors++;
        end
    endtask

    task automatic check_angle(input int row, input string name, input angle_t got,
                               input angle_t expected);
        assert (got == expected) else begin
            $display("MISMATCH at %0t: row %0d angle %s is %0d, expected %0d",
                     $time, row, name, got, expected);
            row_errors++;
        end
    endtask

    initial begin
        int hu, hv, hw;
        int comp_bad;
        int low_bad;
        rst_n    = 1'b0;
        enable   = 1'b0;
        mode     = mode_run;
        velocity = '0;
        offset   = '0;
        feedback = '0;
        void'($urandom(32'h070b1ea8));

        fill_row(0, 1'b1, mode_run, 50, 0, 16'h0120);
        fill_row(1, 1'b1, mode_run, -60, 5, 16'h0350);
        fill_row(2, 1'b1, mode_run, 0, 3, 16'h0200);
        fill_row(3, 1'b1, mode_calibrate, 80, -7, 16'h0410);
        fill_row(4, 1'b1, mode_test, 40, 12, 16'hffff);
        fill_row(5, 1'b1, mode_run, 300, 0, 16'h0008);     // Peak angle with saturated volt
        fill_row(6, 1'b1, mode_run, -32768, 0, 16'h0200);  // Peak through negative lead
        fill_row(7, 1'b1, mode_run, 100, $urandom_range(255, 0) - 128, $urandom_range(65535, 0));
        fill_row(8, 1'b1, mode_calibrate, -100, $urandom_range(255, 0) - 128,
                 $urandom_range(65535, 0));
        fill_row(9, 1'b0, mode_run, 90, 20, 16'h0300);
        fill_row(10, 1'b1, mode_test, 70, $urandom_range(255, 0) - 128, $urandom_range(65535, 0));

        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < NUM_ROWS; i++) begin
            @(negedge clk);
            enable   = rows[i].en;
            mode     = rows[i].md;
            velocity = velocity_t'(rows[i].vel);
            offset   = offset_t'(rows[i].ofs);
            feedback = feedback_t'(rows[i].fb);
            row_errors = 0;
            repeat (SETTLE_CYC) @(negedge clk);

            check_angle(i, "u", dut_i.angle_u, rows[i].ang_u);
            check_angle(i, "v", dut_i.angle_v, rows[i].ang_v);
            check_angle(i, "w", dut_i.angle_w, rows[i].ang_w);

            hu = 0;
            hv = 0;
            hw = 0;
            comp_bad = 0;
            low_bad = 0;
            repeat (PERIOD_CYC) begin
                @(negedge clk);
                if (u) hu++;
                if (v) hv++;
                if (w) hw++;
                if (rows[i].en) begin
                    if (u_n !== ~u || v_n !== ~v || w_n !== ~w) comp_bad++;
                end else if ({u, v, w, u_n, v_n, w_n} !== 6'b0) begin
                    low_bad++;
                end
            end

            check_phase(i, "u", hu, rows[i].exp_u);
            check_phase(i, "v", hv, rows[i].exp_v);
            check_phase(i, "w", hw, rows[i].exp_w);
            assert (comp_bad == 0) else begin
                $display("MISMATCH at %0t: row %0d low side not inverse of high side in %0d cycles",
                         $time, i, comp_bad);
                row_errors++;
            end
            assert (low_bad == 0) else begin
                $display("MISMATCH at %0t: row %0d gate outputs driven in %0d cycles while disabled",
                         $time, i, low_bad);
                row_errors++;
            end

            $display("Row %0d %s vel %0d ofs %0d fb %0d: %s", i, rows[i].md.name(),
                     rows[i].vel, rows[i].ofs, rows[i].fb, (row_errors == 0) ? "ok" : "FAILED");
            errors += row_errors;
            if (row_errors != 0) failed_rows++;
        end

        $display("Rows run %0d, rows failed %0d, failed checks %0d", NUM_ROWS, failed_rows, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
